//--- source/isaPkg.sv
package isaPkg;

	// Datapath sizes
	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int numRegs = 32;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] opSpecial = 6'b000000; // R-type, funct selects
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;

	// Funct codes for opSpecial, instr[5:0]
	localparam logic [5:0] fnSll = 6'b000000; // Fixed shifts use shamt
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

endpackage

//--- source/uopPkg.sv
package uopPkg;

	import isaPkg::*;

	// ALU function carried by a decoded operation
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra
	} aluOpT;

	// One decoded instruction, 52 bits
	typedef struct packed {
		aluOpT aluOp;
		regAddrT srcA;
		regAddrT srcB;
		logic useImm; // Operand B from imm instead of srcB
		wordT imm; // Already extended or shifted
		regAddrT dest;
	} decodedOpT;

	// Retired result, 37 bits
	typedef struct packed {
		regAddrT dest;
		wordT data;
	} resultT;

	localparam int opQueueDepth = 4;

endpackage

//--- source/regFile.sv
`timescale 1ns/1ns

module regFile import isaPkg::*; (
	input logic CLK,
	input logic reset,
	input regAddrT readAddrA,
	output wordT readDataA,
	input regAddrT readAddrB,
	output wordT readDataB,
	input logic writeEnable,
	input regAddrT writeAddr,
	input wordT writeData
);

	wordT regs [numRegs];

	// Two asynchronous read ports
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData; // r0 never written
		end
	end

endmodule

//--- source/opQueue.sv
`timescale 1ns/1ns

module opQueue #(
	parameter type payloadT = logic,
	parameter int depth = 4
) (
	input logic CLK,
	input logic reset,
	input logic inValid,
	input payloadT inData,
	output logic inReady,
	output logic outValid,
	output payloadT outData,
	input logic outReady
);

	payloadT mem [depth];
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth + 1)-1:0] count;
	logic push;
	logic pop;

	assign inReady = (count != ($clog2(depth + 1))'(depth));
	assign outValid = (count != '0);
	assign outData = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	// Pointers and occupancy
	always_ff @(posedge CLK) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ($clog2(depth))'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ($clog2(depth))'(depth - 1)) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			mem[wrPtr] <= inData;
	end

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import isaPkg::*, uopPkg::*; (
	input logic CLK,
	input logic reset,
	input logic instrValid,
	input wordT instr,
	output logic instrReady,
	output logic opValid,
	output decodedOpT op,
	input logic opReady,
	output logic illegalSeen
);

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	logic [4:0] shamt;
	logic [15:0] immediate;
	wordT signImm;
	wordT zeroImm;
	decodedOpT decoded;
	logic legal;
	logic armed; // Set from the first cycle out of reset
	logic accept;

	// Instruction fields
	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign immediate = instr[15:0];
	assign funct = instr[5:0];

	assign signImm = {{(wordWidth - 16){immediate[15]}}, immediate};
	assign zeroImm = {{(wordWidth - 16){1'b0}}, immediate};

	always_comb begin
		// I-type defaults, rt is the destination
		decoded.aluOp = aluAdd;
		decoded.srcA = rs;
		decoded.srcB = rt;
		decoded.useImm = 1'b1;
		decoded.imm = signImm;
		decoded.dest = rt;
		legal = 1'b1;
		case (opcode)
			opSpecial: begin
				decoded.useImm = 1'b0;
				decoded.dest = rd;
				case (funct)
					fnAdd, fnAddu: decoded.aluOp = aluAdd;
					fnSub, fnSubu: decoded.aluOp = aluSub;
					fnAnd: decoded.aluOp = aluAnd;
					fnOr: decoded.aluOp = aluOr;
					fnNor: decoded.aluOp = aluNor;
					fnXor: decoded.aluOp = aluXor;
					fnSlt: decoded.aluOp = aluSlt;
					fnSltu: decoded.aluOp = aluSltu;
					fnSll, fnSrl, fnSra: begin
						// Shift rt by shamt
						decoded.srcA = rt;
						decoded.useImm = 1'b1;
						decoded.imm = {27'd0, shamt};
						if (funct == fnSll)
							decoded.aluOp = aluSll;
						else if (funct == fnSrl)
							decoded.aluOp = aluSrl;
						else
							decoded.aluOp = aluSra;
					end
					default: legal = 1'b0;
				endcase
			end
			opAddi, opAddiu: decoded.aluOp = aluAdd;
			opSlti: decoded.aluOp = aluSlt;
			opSltiu: decoded.aluOp = aluSltu; // Sign-extended, compared unsigned
			opAndi: begin
				decoded.aluOp = aluAnd;
				decoded.imm = zeroImm;
			end
			opOri: begin
				decoded.aluOp = aluOr;
				decoded.imm = zeroImm;
			end
			opXori: begin
				decoded.aluOp = aluXor;
				decoded.imm = zeroImm;
			end
			opLui: begin
				// r0 | (imm << 16)
				decoded.aluOp = aluOr;
				decoded.srcA = '0;
				decoded.imm = {immediate, 16'h0000};
			end
			default: legal = 1'b0;
		endcase
	end

	assign instrReady = armed && (!opValid || opReady);
	assign accept = instrValid && instrReady;

	always_ff @(posedge CLK) begin
		if (reset) begin
			armed <= 1'b0;
			opValid <= 1'b0;
			illegalSeen <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (accept) begin
				opValid <= legal; // Illegal words leave the register empty
				if (!legal)
					illegalSeen <= 1'b1;
			end else if (opReady) begin
				opValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept && legal)
			op <= decoded;
	end

endmodule

//--- source/aluExecutor.sv
`timescale 1ns/1ns

module aluExecutor import isaPkg::*, uopPkg::*; (
	input logic CLK,
	input logic reset,
	input logic issueValid,
	input decodedOpT issueOp,
	output logic issueReady,
	output logic retireValid,
	output resultT retire,
	input logic retireReady
);

	wordT regA;
	wordT regB;
	wordT operandA;
	wordT operandB;
	wordT aluResult;
	logic [4:0] shiftAmount;
	logic fire;

	// Operand fetch
	regFile regs (
		.CLK(CLK),
		.reset(reset),
		.readAddrA(issueOp.srcA),
		.readDataA(regA),
		.readAddrB(issueOp.srcB),
		.readDataB(regB),
		.writeEnable(fire),
		.writeAddr(issueOp.dest),
		.writeData(aluResult)
	);

	assign operandA = regA;
	assign operandB = issueOp.useImm ? issueOp.imm : regB;
	assign shiftAmount = operandB[4:0];

	// One operation per cycle, only with room downstream
	assign issueReady = retireReady;
	assign fire = issueValid && retireReady;

	always_comb begin
		case (issueOp.aluOp)
			aluAdd: aluResult = operandA + operandB; // Wraps, no trap
			aluSub: aluResult = operandA - operandB;
			aluAnd: aluResult = operandA & operandB;
			aluOr: aluResult = operandA | operandB;
			aluNor: aluResult = ~(operandA | operandB);
			aluXor: aluResult = operandA ^ operandB;
			aluSlt: begin
				aluResult = '0;
				aluResult[0] = $signed(operandA) < $signed(operandB);
			end
			aluSltu: begin
				aluResult = '0;
				aluResult[0] = operandA < operandB;
			end
			aluSll: aluResult = operandA << shiftAmount;
			aluSrl: aluResult = operandA >> shiftAmount;
			aluSra: aluResult = $signed(operandA) >>> shiftAmount; // Sign fill
			default: aluResult = '0;
		endcase
	end

	// Retire stage, holds until the result queue takes it
	always_ff @(posedge CLK) begin
		if (reset) begin
			retireValid <= 1'b0;
		end else if (fire) begin
			retireValid <= 1'b1;
		end else if (retireReady) begin
			retireValid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (fire) begin
			retire.dest <= issueOp.dest;
			retire.data <= aluResult; // Reported even for r0
		end
	end

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ns

module mipsCore import isaPkg::*, uopPkg::*; (
	input logic CLK,
	input logic reset,
	input logic instrValid,
	input wordT instr,
	output logic instrReady,
	output logic resultValid,
	output regAddrT resultReg,
	output wordT resultData,
	input logic resultReady,
	output logic illegalSeen
);

	logic opValid;
	logic opReady;
	decodedOpT op;
	logic issueValid;
	logic issueReady;
	decodedOpT issueOp;
	logic retireValid;
	logic retireReady;
	resultT retire;
	resultT resultOut;

	instrDecoder decoder (
		.CLK(CLK),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrReady(instrReady),
		.opValid(opValid),
		.op(op),
		.opReady(opReady),
		.illegalSeen(illegalSeen)
	);

	// Decoded operations waiting for the executor
	opQueue #(.payloadT(decodedOpT), .depth(opQueueDepth)) opFifo (
		.CLK(CLK),
		.reset(reset),
		.inValid(opValid),
		.inData(op),
		.inReady(opReady),
		.outValid(issueValid),
		.outData(issueOp),
		.outReady(issueReady)
	);

	aluExecutor executor (
		.CLK(CLK),
		.reset(reset),
		.issueValid(issueValid),
		.issueOp(issueOp),
		.issueReady(issueReady),
		.retireValid(retireValid),
		.retire(retire),
		.retireReady(retireReady)
	);

	opQueue #(.payloadT(resultT), .depth(opQueueDepth)) resultFifo (
		.CLK(CLK),
		.reset(reset),
		.inValid(retireValid),
		.inData(retire),
		.inReady(retireReady),
		.outValid(resultValid),
		.outData(resultOut),
		.outReady(resultReady)
	);

	assign resultReg = resultOut.dest;
	assign resultData = resultOut.data;

endmodule

//--- verif/mipsCore_asserts.sv
`timescale 1ns/1ns

module mipsCoreAsserts import isaPkg::*; (
	input logic CLK,
	input logic reset,
	input logic instrReady,
	input logic resultValid,
	input logic resultReady,
	input regAddrT resultReg,
	input wordT resultData
);

	// Quiet handshake after every reset edge
	resetQuiet: assert property (@(posedge CLK) reset |=> !resultValid && !instrReady)
		else $error("resultValid or instrReady high during reset");

	// Stalled result keeps its payload
	payloadStable: assert property (@(posedge CLK) disable iff (reset)
		resultValid && !resultReady |=> $stable(resultReg) && $stable(resultData))
		else $error("result payload changed while stalled");

	validHeld: assert property (@(posedge CLK) disable iff (reset)
		resultValid && !resultReady |=> resultValid)
		else $error("resultValid dropped without a transfer");

endmodule

bind mipsCore mipsCoreAsserts asserts (
	.CLK(CLK),
	.reset(reset),
	.instrReady(instrReady),
	.resultValid(resultValid),
	.resultReady(resultReady),
	.resultReg(resultReg),
	.resultData(resultData)
);

//--- verif/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb;

	localparam int waitLimit = 200; // Cycles allowed per wait

	// MIPS opcode and funct encodings
	localparam logic [5:0] opcAddi = 6'h08;
	localparam logic [5:0] opcAddiu = 6'h09;
	localparam logic [5:0] opcSlti = 6'h0a;
	localparam logic [5:0] opcSltiu = 6'h0b;
	localparam logic [5:0] opcAndi = 6'h0c;
	localparam logic [5:0] opcOri = 6'h0d;
	localparam logic [5:0] opcXori = 6'h0e;
	localparam logic [5:0] opcLui = 6'h0f;
	localparam logic [5:0] opcLw = 6'h23; // Load word is not in the subset
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnMult = 6'h18; // Outside the subset
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	typedef struct packed {
		logic [31:0] word;
		logic legal;
		logic [4:0] dest;
		logic [31:0] data;
	} rowT;

	logic CLK;
	logic reset;
	logic instrValid;
	logic [31:0] instr;
	logic instrReady;
	logic resultValid;
	logic [4:0] resultReg;
	logic [31:0] resultData;
	logic resultReady;
	logic illegalSeen;
	integer seed;
	logic [31:0] randomWord;
	rowT rows[$];

	mipsCore dut (
		.CLK(CLK),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrReady(instrReady),
		.resultValid(resultValid),
		.resultReg(resultReg),
		.resultData(resultData),
		.resultReady(resultReady),
		.illegalSeen(illegalSeen)
	);

	function automatic logic [31:0] encodeR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [4:0] sa);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] opc, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic void expectResult(logic [31:0] word, logic [4:0] dest, logic [31:0] data);
		rows.push_back({word, 1'b1, dest, data});
	endfunction

	function automatic void expectIllegal(logic [31:0] word);
		rows.push_back({word, 1'b0, 5'd0, 32'd0});
	endfunction

	// Program order with the expected register and value per row
	function automatic void buildTable();
		expectResult(encodeI(opcAddi, 5'd0, 5'd1, 16'hfffb), 5'd1, 32'hfffffffb);
		expectResult(encodeI(opcOri, 5'd0, 5'd2, 16'h8001), 5'd2, 32'h00008001);
		expectResult(encodeI(opcXori, 5'd1, 5'd3, 16'h8000), 5'd3, 32'hffff7ffb);
		expectResult(encodeI(opcLui, 5'd0, 5'd4, 16'h7fff), 5'd4, 32'h7fff0000);
		expectResult(encodeI(opcOri, 5'd4, 5'd4, 16'hffff), 5'd4, 32'h7fffffff);
		expectResult(encodeI(opcAndi, 5'd3, 5'd5, 16'hf0f3), 5'd5, 32'h000070f3);
		expectResult(encodeI(opcAddiu, 5'd0, 5'd6, 16'h0001), 5'd6, 32'h00000001);
		expectResult(encodeR(fnAdd, 5'd4, 5'd6, 5'd7, 5'd0), 5'd7, 32'h80000000); // Wraps
		expectResult(encodeR(fnAddu, 5'd1, 5'd2, 5'd8, 5'd0), 5'd8, 32'h00007ffc);
		expectResult(encodeR(fnSub, 5'd2, 5'd1, 5'd9, 5'd0), 5'd9, 32'h00008006);
		expectResult(encodeR(fnSubu, 5'd6, 5'd4, 5'd10, 5'd0), 5'd10, 32'h80000002);
		expectResult(encodeR(fnAnd, 5'd3, 5'd2, 5'd11, 5'd0), 5'd11, 32'h00000001);
		expectResult(encodeR(fnOr, 5'd2, 5'd4, 5'd12, 5'd0), 5'd12, 32'h7fffffff);
		expectResult(encodeR(fnNor, 5'd2, 5'd6, 5'd13, 5'd0), 5'd13, 32'hffff7ffe);
		expectResult(encodeR(fnXor, 5'd1, 5'd4, 5'd14, 5'd0), 5'd14, 32'h80000004);
		// Compare -5 against 1 signed and unsigned
		expectResult(encodeR(fnSlt, 5'd1, 5'd6, 5'd15, 5'd0), 5'd15, 32'h00000001);
		expectResult(encodeR(fnSltu, 5'd1, 5'd6, 5'd16, 5'd0), 5'd16, 32'h00000000);
		expectResult(encodeI(opcSlti, 5'd1, 5'd17, 16'h0002), 5'd17, 32'h00000001);
		expectResult(encodeI(opcSltiu, 5'd1, 5'd18, 16'h0002), 5'd18, 32'h00000000);
		expectResult(encodeI(opcOri, 5'd7, 5'd19, 16'h0010), 5'd19, 32'h80000010);
		expectResult(encodeR(fnSll, 5'd0, 5'd19, 5'd20, 5'd4), 5'd20, 32'h00000100);
		expectResult(encodeR(fnSrl, 5'd0, 5'd19, 5'd21, 5'd4), 5'd21, 32'h08000001);
		expectResult(encodeR(fnSra, 5'd0, 5'd19, 5'd22, 5'd4), 5'd22, 32'hf8000001);
		expectResult(encodeI(opcAddi, 5'd6, 5'd0, 16'h1234), 5'd0, 32'h00001235); // r0 target
		expectResult(encodeR(fnAddu, 5'd0, 5'd6, 5'd23, 5'd0), 5'd23, 32'h00000001);
		expectIllegal(encodeI(opcLw, 5'd1, 5'd2, 16'h0000));
		expectIllegal(encodeR(fnMult, 5'd1, 5'd2, 5'd0, 5'd0));
		expectResult(encodeI(opcAddiu, 5'd6, 5'd24, 16'hffff), 5'd24, 32'h00000000);
		expectResult(encodeR(fnSlt, 5'd6, 5'd1, 5'd25, 5'd0), 5'd25, 32'h00000000);
		expectResult(encodeR(fnSltu, 5'd6, 5'd1, 5'd26, 5'd0), 5'd26, 32'h00000001);
	endfunction

	task automatic failRun(string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
			failRun($sformatf("error: %s = 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	task automatic driveInstructions();
		int waitCycles;
		bit illegalDone;
		illegalDone = 1'b0;
		foreach (rows[i]) begin
			@(negedge CLK);
			if (!rows[i].legal && !illegalDone)
				checkValue("illegalSeen", {31'd0, illegalSeen}, 32'h0);
			instrValid = 1'b1;
			instr = rows[i].word;
			waitCycles = 0;
			do begin
				@(posedge CLK);
				waitCycles++;
				if (waitCycles > waitLimit)
					failRun($sformatf("instruction %0d was never accepted", i));
			end while (!instrReady);
			if (!rows[i].legal) begin
				@(negedge CLK);
				instrValid = 1'b0;
				@(posedge CLK); // Flag is due one cycle after acceptance
				checkValue("illegalSeen", {31'd0, illegalSeen}, 32'h1);
				illegalDone = 1'b1;
			end
		end
		@(negedge CLK);
		instrValid = 1'b0;
	endtask

	// Results in program order with illegal rows skipped
	task automatic collectResults();
		int waitCycles;
		foreach (rows[i]) begin
			if (rows[i].legal) begin
				waitCycles = 0;
				do begin
					@(posedge CLK);
					waitCycles++;
					if (waitCycles > waitLimit)
						failRun($sformatf("no result arrived for instruction %0d", i));
				end while (!(resultValid && resultReady));
				checkValue($sformatf("resultReg[%0d]", i), {27'd0, resultReg},
					{27'd0, rows[i].dest});
				checkValue($sformatf("resultData[%0d]", i), resultData, rows[i].data);
			end
		end
	endtask

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Random back-pressure on the result port
	initial begin
		seed = 32'h61198e11;
		resultReady = 1'b0;
		forever begin
			@(negedge CLK);
			randomWord = $random(seed);
			resultReady = randomWord[0];
		end
	end

	initial begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		buildTable();
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		fork
			driveInstructions();
			collectResults();
		join
		repeat (20) begin
			@(posedge CLK);
			if (resultValid)
				failRun("a result arrived after the last expected one");
		end
		checkValue("illegalSeen", {31'd0, illegalSeen}, 32'h1); // Still sticky
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog.f
source/isaPkg.sv
source/uopPkg.sv
source/regFile.sv
source/opQueue.sv
source/instrDecoder.sv
source/aluExecutor.sv
source/mipsCore.sv
verif/mipsCore_asserts.sv
verif/mipsCoreTb.sv

//--- Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module mipsCoreTb

run: build
	./obj_dir/VmipsCoreTb 2>&1 | tee $(LOG)
	@grep -qx "All tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module mipsCoreTb

clean:
	rm -rf obj_dir $(LOG)
